// ==== filelist.f ====
+incdir+source
source/bitstream_pkg.sv
source/code_fifo.sv
source/component_scheduler.sv
source/bit_packer.sv
source/bitstream_merge.sv
dv/bitstream_merge_assertions.sv
dv/bitstream_merge_tb.sv

// ==== Makefile ====
# Verilator build and run of the bitstream merge testbench

SIM      = verilator
TOP      = bitstream_merge_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, exit status gives pass or fail"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/bitstream_merge_tb.sv ====
// Testbench for bitstream_merge, stops at the first error
// Partial words are never flushed, so leftover bits carry from one test into the next

`timescale 1ns/1ns
`include "bitstream_defs.svh"

module bitstream_merge_tb;
	import bitstream_pkg::*;

	localparam int FULL_CODES     = 2 * `BS_COMPONENTS;
	localparam int RAND_CODES     = 4 * 8 * `BS_COMPONENTS;
	localparam int ORDER_CODES    = 6 * `BS_COMPONENTS;
	localparam int BURST_CODES    = 3 * 20 * `BS_COMPONENTS;
	localparam int ALL_CODES      = FULL_CODES + RAND_CODES + ORDER_CODES + BURST_CODES;
	localparam int TIMEOUT_CYCLES = 40 * ALL_CODES + 200;
	localparam int DRAIN_CYCLES   = `BS_FIFO_DEPTH * `BS_COMPONENTS + 8; // Leftover codes empty out

	logic                      clk = 1'b0;
	logic                      rst;
	code_word_t                in_code [`BS_COMPONENTS];
	logic                      in_valid [`BS_COMPONENTS];
	logic                      in_ready [`BS_COMPONENTS];
	logic [`BS_WORD_WIDTH-1:0] word;
	logic                      word_valid;
	logic                      word_ready = 1'b1;
	logic [`BS_LEN_WIDTH-1:0]  fill_bits;

	integer seed = 42;
	int     cycles = 0;
	int     leftover = 0;
	bit     bp_mode = 1'b0;

	code_word_t                in_q [`BS_COMPONENTS][$]; // Codes still to send, per component
	logic [`BS_WORD_WIDTH-1:0] exp_words [$];
	bit                        carry_bits [$];           // Bits not yet in a full word

	bitstream_merge bitstream_merge_inst (
		.clk        (clk),
		.rst        (rst),
		.y_code     (in_code[COMP_Y]),
		.y_valid    (in_valid[COMP_Y]),
		.y_ready    (in_ready[COMP_Y]),
		.cb_code    (in_code[COMP_CB]),
		.cb_valid   (in_valid[COMP_CB]),
		.cb_ready   (in_ready[COMP_CB]),
		.cr_code    (in_code[COMP_CR]),
		.cr_valid   (in_valid[COMP_CR]),
		.cr_ready   (in_ready[COMP_CR]),
		.word       (word),
		.word_valid (word_valid),
		.word_ready (word_ready),
		.fill_bits  (fill_bits)
	);

	always #4 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [`BS_WORD_WIDTH-1:0] got,
			input logic [`BS_WORD_WIDTH-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_fill(input string name, input logic [`BS_LEN_WIDTH-1:0] got,
			input logic [`BS_LEN_WIDTH-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// MSB-first concatenation of the low len bits, cut into full words
	function automatic int pack_codes(input code_word_t codes[$]);
		logic [`BS_WORD_WIDTH-1:0] w;
		foreach (codes[i])
		begin
			for (int b = int'(codes[i].len) - 1; b >= 0; b--)
				carry_bits.push_back(codes[i].bits[b]);
		end
		while (carry_bits.size() >= `BS_WORD_WIDTH)
		begin
			for (int b = `BS_WORD_WIDTH - 1; b >= 0; b--)
				w[b] = carry_bits.pop_front();
			exp_words.push_back(w);
		end
		return carry_bits.size();
	endfunction

	task automatic build_blocks(input int rounds, input int per_block, input bit full_len);
		code_word_t order [$];
		code_word_t cw;
		for (int r = 0; r < rounds; r++)
			for (int c = 0; c < `BS_COMPONENTS; c++)
				for (int k = 0; k < per_block; k++)
				begin
					cw.len  = full_len ? `BS_LEN_WIDTH'(`BS_WORD_WIDTH) :
						`BS_LEN_WIDTH'($unsigned($random(seed)) % `BS_WORD_WIDTH + 1);
					cw.bits = $random(seed) & ({`BS_WORD_WIDTH{1'b1}} >> (`BS_WORD_WIDTH - cw.len));
					cw.last = (k == per_block - 1);
					in_q[c].push_back(cw);
					order.push_back(cw); // Scheduled order Y, Cb, Cr
				end
		leftover = pack_codes(order);
	endtask

	// Called 1 ns after a rising edge, holds each code until it is taken
	task automatic drive_component(input int c, input int start_delay);
		logic rdy;
		repeat (start_delay)
		begin
			@(posedge clk);
			#1;
		end
		while (in_q[c].size() > 0)
		begin
			in_code[c]  = in_q[c].pop_front();
			in_valid[c] = 1'b1;
			do
			begin
				rdy = in_ready[c]; // Stable until the next edge
				@(posedge clk);
				#1;
			end while (!rdy);
		end
		in_valid[c] = 1'b0;
	endtask

	task automatic run_stream(input int y_delay);
		fork
			drive_component(COMP_Y, y_delay);
			drive_component(COMP_CB, 0);
			drive_component(COMP_CR, 0);
		join
		while (exp_words.size() > 0)
			@(posedge clk);
		repeat (DRAIN_CYCLES) @(posedge clk);
		@(negedge clk);
		check_bit("word_valid", word_valid, 1'b0);
		check_fill("fill_bits", fill_bits, `BS_LEN_WIDTH'(leftover));
		@(posedge clk);
		#1;
	endtask

	// About one word in four accepted under back-pressure
	always @(posedge clk)
	begin
		#1;
		word_ready = bp_mode ? (($random(seed) & 3) == 0) : 1'b1;
	end

	always @(negedge clk)
	begin
		if (!rst && word_valid && word_ready)
		begin
			if (exp_words.size() == 0)
				abort_run($sformatf("Output word 0x%h arrived when none was expected", word));
			else
				check_word("word", word, exp_words.pop_front());
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES)
			abort_run($sformatf("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
	end

	initial
	begin
		rst = 1'b1;
		for (int c = 0; c < `BS_COMPONENTS; c++)
		begin
			in_code[c]  = '0;
			in_valid[c] = 1'b0;
		end
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_bit("word_valid", word_valid, 1'b0);
		check_fill("fill_bits", fill_bits, '0);
		check_bit("y_ready", in_ready[COMP_Y], 1'b1);
		check_bit("cb_ready", in_ready[COMP_CB], 1'b1);
		check_bit("cr_ready", in_ready[COMP_CR], 1'b1);
		@(posedge clk);
		#1;

		build_blocks(1, 2, 1'b1); // Words equal the codes, Y Y Cb Cb Cr Cr
		run_stream(0);

		build_blocks(4, 8, 1'b0);
		run_stream(0);

		// Y arrives late, Cb and Cr wait in their FIFOs
		build_blocks(1, 6, 1'b0);
		run_stream(30);

		bp_mode = 1'b1;
		build_blocks(3, 20, 1'b0);
		run_stream(0);
		bp_mode = 1'b0;

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== dv/bitstream_merge_assertions.sv ====
// Handshake checks bound into every bitstream_merge instance
// Uses only the top level's ports, so it holds for any packer internals

`timescale 1ns/1ns
`include "bitstream_defs.svh"

module bitstream_merge_assertions (
	input logic                      clk,
	input logic                      rst,
	input logic [`BS_WORD_WIDTH-1:0] word,
	input logic                      word_valid,
	input logic                      word_ready,
	input logic [`BS_LEN_WIDTH-1:0]  fill_bits
);
	import bitstream_pkg::*;

	// A stalled word stays offered and unchanged
	stalled_word_holds: assert property (@(posedge clk) disable iff (rst)
		word_valid && !word_ready |=> word_valid && $stable(word))
		else $error("output word changed or dropped while stalled");

	// A full packer only holds its bits or drops one word, it never grows
	no_take_when_full: assert property (@(posedge clk) disable iff (rst)
		fill_bits >= `BS_LEN_WIDTH'(`BS_WORD_WIDTH) |=>
			fill_bits == $past(fill_bits) ||
			fill_bits == $past(fill_bits) - `BS_LEN_WIDTH'(`BS_WORD_WIDTH))
		else $error("packer accepted a code while holding a full word");

	valid_low_after_reset: assert property (@(posedge clk) rst |=> !word_valid)
		else $error("word_valid high in the cycle after reset");

endmodule

bind bitstream_merge bitstream_merge_assertions bitstream_merge_assertions_inst (
	.clk        (clk),
	.rst        (rst),
	.word       (word),
	.word_valid (word_valid),
	.word_ready (word_ready),
	.fill_bits  (fill_bits)
);

// ==== source/bitstream_merge.sv ====
// Merges the Y, Cb and Cr code streams into one 32-bit word stream
// Producers must mark every block end with last, or scheduling stops

`timescale 1ns/1ns
`include "bitstream_defs.svh"

module bitstream_merge (
	input  logic                       clk,
	input  logic                       rst,
	input  bitstream_pkg::code_word_t  y_code,
	input  logic                       y_valid,
	output logic                       y_ready,
	input  bitstream_pkg::code_word_t  cb_code,
	input  logic                       cb_valid,
	output logic                       cb_ready,
	input  bitstream_pkg::code_word_t  cr_code,
	input  logic                       cr_valid,
	output logic                       cr_ready,
	output logic [`BS_WORD_WIDTH-1:0]  word,
	output logic                       word_valid,
	input  logic                       word_ready,
	output logic [`BS_LEN_WIDTH-1:0]   fill_bits
);
	import bitstream_pkg::*;

	// FIFO heads, indexed by component
	code_word_t fifo_code  [`BS_COMPONENTS];
	logic       fifo_valid [`BS_COMPONENTS];
	logic       fifo_ready [`BS_COMPONENTS];

	// Scheduler to packer
	code_word_t packer_code;
	logic       packer_valid;
	logic       packer_ready;

	code_fifo #(.DEPTH(`BS_FIFO_DEPTH)) y_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_code   (y_code),
		.in_valid  (y_valid),
		.in_ready  (y_ready),
		.out_code  (fifo_code[COMP_Y]),
		.out_valid (fifo_valid[COMP_Y]),
		.out_ready (fifo_ready[COMP_Y])
	);

	code_fifo #(.DEPTH(`BS_FIFO_DEPTH)) cb_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_code   (cb_code),
		.in_valid  (cb_valid),
		.in_ready  (cb_ready),
		.out_code  (fifo_code[COMP_CB]),
		.out_valid (fifo_valid[COMP_CB]),
		.out_ready (fifo_ready[COMP_CB])
	);

	code_fifo #(.DEPTH(`BS_FIFO_DEPTH)) cr_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_code   (cr_code),
		.in_valid  (cr_valid),
		.in_ready  (cr_ready),
		.out_code  (fifo_code[COMP_CR]),
		.out_valid (fifo_valid[COMP_CR]),
		.out_ready (fifo_ready[COMP_CR])
	);

	component_scheduler component_scheduler_inst (
		.clk        (clk),
		.rst        (rst),
		.fifo_code  (fifo_code),
		.fifo_valid (fifo_valid),
		.fifo_ready (fifo_ready),
		.code       (packer_code),
		.code_valid (packer_valid),
		.code_ready (packer_ready)
	);

	bit_packer bit_packer_inst (
		.clk        (clk),
		.rst        (rst),
		.code       (packer_code),
		.code_valid (packer_valid),
		.code_ready (packer_ready),
		.word       (word),
		.word_valid (word_valid),
		.word_ready (word_ready),
		.fill_bits  (fill_bits)
	);

endmodule

// ==== source/bit_packer.sv ====
// Packs variable-length codes MSB first into 32-bit words, no stuffing and no flush
// A partial word stays in the accumulator and shows only through fill_bits

`timescale 1ns/1ns
`include "bitstream_defs.svh"

module bit_packer (
	input  logic                       clk,
	input  logic                       rst,
	input  bitstream_pkg::code_word_t  code,
	input  logic                       code_valid,
	output logic                       code_ready,
	output logic [`BS_WORD_WIDTH-1:0]  word,
	output logic                       word_valid,
	input  logic                       word_ready,
	output logic [`BS_LEN_WIDTH-1:0]   fill_bits
);
	import bitstream_pkg::*;

	localparam int ACC_W = 2 * `BS_WORD_WIDTH;

	logic [ACC_W-1:0]          acc; // Left-aligned, bits below fill_bits are zero
	logic [ACC_W-1:0]          placed;
	logic [`BS_LEN_WIDTH-1:0]  fill;
	logic                      take;
	logic                      pop;
	logic                      full_word;

	// Move the len low bits of a code to the top of a 64-bit field
	function automatic logic [ACC_W-1:0] align_code(input code_word_t c);
		logic [`BS_LEN_WIDTH:0] shamt;
		shamt = (`BS_LEN_WIDTH+1)'(`BS_WORD_WIDTH) - {1'b0, c.len};
		return {c.bits, {`BS_WORD_WIDTH{1'b0}}} << shamt; // Upper junk falls off
	endfunction

	assign full_word  = (fill >= `BS_LEN_WIDTH'(`BS_WORD_WIDTH));
	assign code_ready = !full_word;
	assign take       = code_valid && code_ready;
	assign pop        = word_valid && word_ready;

	// New code goes just below the bits already held
	assign placed = align_code(code) >> fill;

	assign word      = acc[ACC_W-1 -: `BS_WORD_WIDTH];
	assign fill_bits = fill;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acc  <= '0;
			fill <= '0;
		end
		else if (pop)
		begin
			// Oldest 32 bits leave, zeros shift in below
			acc  <= acc << `BS_WORD_WIDTH;
			fill <= fill - `BS_LEN_WIDTH'(`BS_WORD_WIDTH);
		end
		else if (take)
		begin
			acc  <= acc | placed;
			fill <= fill + code.len; // At most 31 + 32
		end
	end

	// Valid one cycle after a full word is held, dropped on its transfer
	always_ff @(posedge clk)
	begin
		if (rst)
			word_valid <= 1'b0;
		else if (pop)
			word_valid <= 1'b0;
		else
			word_valid <= full_word;
	end

endmodule

// ==== source/component_scheduler.sv ====
// Drains one whole block per component in the order Y, Cb, Cr
// Blocks are delimited only by the last flag, a missing flag stalls the other two

`timescale 1ns/1ns
`include "bitstream_defs.svh"

module component_scheduler (
	input  logic                    clk,
	input  logic                    rst,
	input  bitstream_pkg::code_word_t fifo_code [`BS_COMPONENTS],
	input  logic                    fifo_valid [`BS_COMPONENTS],
	output logic                    fifo_ready [`BS_COMPONENTS],
	output bitstream_pkg::code_word_t code,
	output logic                    code_valid,
	input  logic                    code_ready
);
	import bitstream_pkg::*;

	component_t cur;
	logic       take;

	function automatic component_t next_comp(input component_t c);
		case (c)
			COMP_Y:  return COMP_CB;
			COMP_CB: return COMP_CR;
			default: return COMP_Y;
		endcase
	endfunction

	// Zero-latency routing of the selected FIFO
	assign code       = fifo_code[cur];
	assign code_valid = fifo_valid[cur];

	always_comb
	begin
		for (int i = 0; i < `BS_COMPONENTS; i++)
			fifo_ready[i] = code_ready && (cur == component_t'(i)); // Others hold
	end

	assign take = code_valid && code_ready;

	always_ff @(posedge clk)
	begin
		if (rst)
			cur <= COMP_Y;
		else if (take && code.last)
			cur <= next_comp(cur); // End of block
	end

endmodule

// ==== source/code_fifo.sv ====
// Circular FIFO of code words, DEPTH of 2 or more, power of two not required
// Head entry is read straight from storage, so a write shows on out_valid one cycle later

`timescale 1ns/1ns
`include "bitstream_defs.svh"

module code_fifo #(
	parameter int DEPTH = `BS_FIFO_DEPTH
) (
	input  logic                    clk,
	input  logic                    rst,
	input  bitstream_pkg::code_word_t in_code,
	input  logic                    in_valid,
	output logic                    in_ready,
	output bitstream_pkg::code_word_t out_code,
	output logic                    out_valid,
	input  logic                    out_ready
);
	import bitstream_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	code_word_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic wr_en;
	logic rd_en;

	// Wraps at DEPTH-1 so odd depths work
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	assign in_ready  = (count != CNT_W'(DEPTH)); // State only, never in_valid
	assign out_valid = (count != '0);
	assign out_code  = mem[rd_ptr];

	assign wr_en = in_valid && in_ready;
	assign rd_en = out_valid && out_ready;

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= in_code;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd_en)
				rd_ptr <= ptr_inc(rd_ptr);

			// Simultaneous read and write leave the count alone
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== source/bitstream_pkg.sv ====
// Types for the bitstream merge stage
// A code of len bits sits in the low bits of the bits field, len of 0 is not allowed

`include "bitstream_defs.svh"

package bitstream_pkg;

	// Variable-length code as delivered by one component
	typedef struct packed {
		logic [`BS_WORD_WIDTH-1:0] bits; // Right-aligned code
		logic [`BS_LEN_WIDTH-1:0]  len;  // 1 to 32
		logic                      last; // End of block
	} code_word_t;

	// Also used as index into per-component arrays
	typedef enum logic [1:0] {
		COMP_Y  = 2'd0,
		COMP_CB = 2'd1,
		COMP_CR = 2'd2
	} component_t;

endpackage

// ==== source/bitstream_defs.svh ====
// Widths and sizes shared by the bitstream merge stage
// Code lengths run 1 to BS_WORD_WIDTH, so BS_LEN_WIDTH must also hold 2*BS_WORD_WIDTH-1

`ifndef BITSTREAM_DEFS_SVH
`define BITSTREAM_DEFS_SVH

// One code field and one output word
`define BS_WORD_WIDTH 32

// Code length and packer fill count (0 to 63)
`define BS_LEN_WIDTH 6

`define BS_FIFO_DEPTH 16 // Default per-component FIFO depth
`define BS_COMPONENTS 3  // Y, Cb, Cr

`endif
